// ==== Makefile ====
# Verilator lint, build-and-simulate and clean for the five-stage core
VERILATOR ?= verilator
TOP       ?= cpu_top_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
rtl/core_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/gpr.sv
rtl/spm.sv
rtl/hazard_ctrl.sv
rtl/cpu_top.sv
verification/cpu_top_tb.sv

// ==== rtl/core_pkg.sv ====
// Core package with datapath widths, opcode enums and pipeline register structs
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;             // Data and address width
    localparam int REG_ADDR_W = 5;              // Register index width

    typedef logic [XLEN-1:0]       word_t;      // Data word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register index

    ////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OP     = 7'b0110011,                    // Register-register ALU
        OP_IMM = 7'b0010011,                    // Register-immediate ALU
        LOAD   = 7'b0000011,                    // LW
        STORE  = 7'b0100011                     // SW
    } insn_op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,                               // Take register file value
        FWD_EX,                                 // Take live ALU result
        FWD_MEM                                 // Take value about to retire
    } fwd_sel_e;

    ////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////
    typedef struct packed {
        logic  en;                              // Slot holds an instruction
        word_t pc;                              // Fetch address
        word_t insn;                            // Raw instruction word
    } if_id_t;

    typedef struct packed {
        logic      en;
        alu_op_e   alu_op;
        word_t     alu_in_0;                    // rs1 after forwarding
        word_t     alu_in_1;                    // rs2 or immediate
        mem_op_e   mem_op;
        word_t     mem_wr_data;                 // Store data
        reg_addr_t rd_addr;
        logic      gpr_we;
    } id_ex_t;

    typedef struct packed {
        logic      en;
        mem_op_e   mem_op;
        word_t     mem_wr_data;
        reg_addr_t rd_addr;
        logic      gpr_we;
        word_t     out;                         // ALU result or byte address
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } gpr_wr_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// CPU top joining the five pipeline stages, register file, SPM and hazard control
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int              SPM_ADDR_W = 8,
    parameter core_pkg::word_t RESET_PC   = 32'h0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        run,           // Fetch enable level
    input  wire                        prog_we,       // Program load strobe
    input  wire [SPM_ADDR_W-1:0]       prog_addr,     // Word address
    input  wire core_pkg::word_t       prog_data,
    output core_pkg::gpr_wr_t          wb             // Retiring writeback
);

    core_pkg::if_id_t       if_id;
    core_pkg::id_ex_t       id_ex;
    core_pkg::ex_mem_t      ex_mem;
    logic [SPM_ADDR_W-1:0]  fetch_addr;             // From PC
    logic [SPM_ADDR_W-1:0]  spm_insn_addr;          // Fetch or load address
    logic [SPM_ADDR_W-1:0]  data_addr;
    logic                   data_we;
    core_pkg::word_t        data_wr;
    core_pkg::word_t        data_rd;
    core_pkg::word_t        insn_data;
    core_pkg::reg_addr_t    rs1_addr;
    core_pkg::reg_addr_t    rs2_addr;
    core_pkg::word_t        rs1_data;
    core_pkg::word_t        rs2_data;
    core_pkg::word_t        ex_fwd_data;
    core_pkg::word_t        mem_fwd_data;
    core_pkg::fwd_sel_e     rs1_fwd_sel;
    core_pkg::fwd_sel_e     rs2_fwd_sel;
    logic                   stall;

    assign spm_insn_addr = run ? fetch_addr : prog_addr;   // Loader owns port while stopped

    ////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////
    if_stage #(.SPM_ADDR_W(SPM_ADDR_W), .RESET_PC(RESET_PC)) if_stage_i (
        .clk(clk), .rst_n(rst_n), .run(run), .stall(stall),
        .insn_addr(fetch_addr), .insn_data(insn_data), .if_id(if_id)
    );

    id_stage id_stage_i (
        .clk(clk), .rst_n(rst_n), .stall(stall), .if_id(if_id),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_fwd_sel(rs1_fwd_sel), .rs2_fwd_sel(rs2_fwd_sel),
        .ex_fwd_data(ex_fwd_data), .mem_fwd_data(mem_fwd_data), .id_ex(id_ex)
    );

    ex_stage ex_stage_i (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex),
        .ex_fwd_data(ex_fwd_data), .ex_mem(ex_mem)
    );

    mem_stage #(.SPM_ADDR_W(SPM_ADDR_W)) mem_stage_i (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem),
        .data_addr(data_addr), .data_we(data_we), .data_wr(data_wr), .data_rd(data_rd),
        .mem_fwd_data(mem_fwd_data), .wb(wb)
    );

    ////////////////////////////////////////////////////
    // Storage and control
    ////////////////////////////////////////////////////
    gpr gpr_i (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wr(wb)
    );

    spm #(.SPM_ADDR_W(SPM_ADDR_W)) spm_i (
        .clk(clk),
        .insn_addr(spm_insn_addr), .insn_we(prog_we), .insn_wr(prog_data),
        .insn_data(insn_data),
        .data_addr(data_addr), .data_we(data_we), .data_wr(data_wr), .data_rd(data_rd)
    );

    hazard_ctrl hazard_ctrl_i (
        .if_insn(if_id.insn), .id_ex(id_ex), .ex_mem(ex_mem),
        .rs1_fwd_sel(rs1_fwd_sel), .rs2_fwd_sel(rs2_fwd_sel), .stall(stall)
    );

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
// Execute stage with the ALU and the EX/MEM pipeline register
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire core_pkg::id_ex_t      id_ex,
    output core_pkg::word_t            ex_fwd_data,   // Combinational ALU result
    output core_pkg::ex_mem_t          ex_mem
);

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::ALU_SUB: ex_fwd_data = id_ex.alu_in_0 - id_ex.alu_in_1;
            core_pkg::ALU_AND: ex_fwd_data = id_ex.alu_in_0 & id_ex.alu_in_1;
            core_pkg::ALU_OR:  ex_fwd_data = id_ex.alu_in_0 | id_ex.alu_in_1;
            core_pkg::ALU_XOR: ex_fwd_data = id_ex.alu_in_0 ^ id_ex.alu_in_1;
            default:           ex_fwd_data = id_ex.alu_in_0 + id_ex.alu_in_1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.en     <= 1'b0;
            ex_mem.gpr_we <= 1'b0;
            ex_mem.mem_op <= core_pkg::MEM_NONE;
        end else begin
            ex_mem.en     <= id_ex.en;
            ex_mem.gpr_we <= id_ex.gpr_we;
            ex_mem.mem_op <= id_ex.mem_op;
        end
        ex_mem.mem_wr_data <= id_ex.mem_wr_data;
        ex_mem.rd_addr     <= id_ex.rd_addr;
        ex_mem.out         <= ex_fwd_data;        // Address for LW and SW
    end

endmodule

`default_nettype wire

// ==== rtl/gpr.sv ====
// General purpose register file with x0 tied to zero and write-through reads
`timescale 1ns/1ps
`default_nettype none

module gpr (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire core_pkg::reg_addr_t   rs1_addr,
    input  wire core_pkg::reg_addr_t   rs2_addr,
    output core_pkg::word_t            rs1_data,
    output core_pkg::word_t            rs2_data,
    input  wire core_pkg::gpr_wr_t     wr             // Writeback port
);

    core_pkg::word_t regs [1:31];                   // x0 has no storage

    always_ff @(posedge clk) begin
        if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Bypass covers an instruction three behind its producer
    assign rs1_data = (rs1_addr == '0)                  ? '0      :
                      (wr.we && (wr.addr == rs1_addr))  ? wr.data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)                  ? '0      :
                      (wr.we && (wr.addr == rs2_addr))  ? wr.data : regs[rs2_addr];

    // Decode must have filtered rd == 0 long before writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> (wr.addr != '0));

endmodule

`default_nettype wire

// ==== rtl/hazard_ctrl.sv ====
// Hazard control picking operand forwarding and detecting load-use stalls
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
    input  wire core_pkg::word_t       if_insn,       // Instruction in decode
    input  wire core_pkg::id_ex_t      id_ex,
    input  wire core_pkg::ex_mem_t     ex_mem,
    output core_pkg::fwd_sel_e         rs1_fwd_sel,
    output core_pkg::fwd_sel_e         rs2_fwd_sel,
    output logic                       stall
);

    core_pkg::insn_op_e  op;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    logic                rs1_used;
    logic                rs2_used;
    logic                ex_load;                   // Load result not ready yet

    function automatic core_pkg::fwd_sel_e fwd_pick(
        input core_pkg::reg_addr_t rs,
        input core_pkg::id_ex_t    ex,
        input core_pkg::ex_mem_t   mem
    );
        if (rs == '0) begin
            return core_pkg::FWD_NONE;
        end
        if (ex.en && ex.gpr_we && (ex.mem_op != core_pkg::MEM_LOAD) && (ex.rd_addr == rs)) begin
            return core_pkg::FWD_EX;                // Youngest producer wins
        end
        if (mem.en && mem.gpr_we && (mem.rd_addr == rs)) begin
            return core_pkg::FWD_MEM;
        end
        return core_pkg::FWD_NONE;
    endfunction

    assign op       = core_pkg::insn_op_e'(if_insn[6:0]);
    assign rs1      = if_insn[19:15];
    assign rs2      = if_insn[24:20];
    assign rs1_used = (op == core_pkg::OP) || (op == core_pkg::OP_IMM) ||
                      (op == core_pkg::LOAD) || (op == core_pkg::STORE);
    assign rs2_used = (op == core_pkg::OP) || (op == core_pkg::STORE);

    assign rs1_fwd_sel = fwd_pick(rs1, id_ex, ex_mem);
    assign rs2_fwd_sel = fwd_pick(rs2, id_ex, ex_mem);

    assign ex_load = id_ex.en && id_ex.gpr_we && (id_ex.mem_op == core_pkg::MEM_LOAD);
    assign stall   = ex_load && ((rs1_used && (rs1 == id_ex.rd_addr)) ||
                                 (rs2_used && (rs2 == id_ex.rd_addr)));

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
// Decode stage with operand forwarding, immediate build and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        stall,         // Insert bubble
    input  wire core_pkg::if_id_t      if_id,
    output core_pkg::reg_addr_t        rs1_addr,      // To register file
    output core_pkg::reg_addr_t        rs2_addr,
    input  wire core_pkg::word_t       rs1_data,      // From register file
    input  wire core_pkg::word_t       rs2_data,
    input  wire core_pkg::fwd_sel_e    rs1_fwd_sel,
    input  wire core_pkg::fwd_sel_e    rs2_fwd_sel,
    input  wire core_pkg::word_t       ex_fwd_data,   // Live ALU result
    input  wire core_pkg::word_t       mem_fwd_data,  // Value about to retire
    output core_pkg::id_ex_t           id_ex
);

    core_pkg::insn_op_e  op;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     imm_i;
    core_pkg::word_t     imm_s;
    core_pkg::word_t     rs1_val;                   // rs1 after forwarding
    core_pkg::word_t     rs2_val;                   // rs2 after forwarding
    core_pkg::alu_op_e   alu_op;
    core_pkg::mem_op_e   mem_op;
    logic                gpr_we;
    logic                valid;                     // Slot survives into EX

    function automatic core_pkg::word_t pick_operand(
        input core_pkg::fwd_sel_e sel,
        input core_pkg::word_t    gpr_val,
        input core_pkg::word_t    ex_val,
        input core_pkg::word_t    mem_val
    );
        case (sel)
            core_pkg::FWD_EX:  return ex_val;
            core_pkg::FWD_MEM: return mem_val;
            default:           return gpr_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////
    assign op       = core_pkg::insn_op_e'(if_id.insn[6:0]);
    assign rd       = if_id.insn[11:7];
    assign rs1_addr = if_id.insn[19:15];
    assign rs2_addr = if_id.insn[24:20];
    assign imm_i    = {{20{if_id.insn[31]}}, if_id.insn[31:20]};
    assign imm_s    = {{20{if_id.insn[31]}}, if_id.insn[31:25], if_id.insn[11:7]};
    assign rs1_val  = pick_operand(rs1_fwd_sel, rs1_data, ex_fwd_data, mem_fwd_data);
    assign rs2_val  = pick_operand(rs2_fwd_sel, rs2_data, ex_fwd_data, mem_fwd_data);
    assign valid    = if_id.en && !stall;

    always_comb begin
        alu_op = core_pkg::ALU_ADD;                 // Loads and stores add
        mem_op = core_pkg::MEM_NONE;
        gpr_we = 1'b0;
        case (op)
            core_pkg::OP, core_pkg::OP_IMM: begin
                gpr_we = 1'b1;
                case (if_id.insn[14:12])            // funct3
                    3'b100:  alu_op = core_pkg::ALU_XOR;
                    3'b110:  alu_op = core_pkg::ALU_OR;
                    3'b111:  alu_op = core_pkg::ALU_AND;
                    default: begin
                        if (op == core_pkg::OP && if_id.insn[30]) begin
                            alu_op = core_pkg::ALU_SUB;     // funct7 bit 5
                        end
                    end
                endcase
            end
            core_pkg::LOAD: begin
                mem_op = core_pkg::MEM_LOAD;
                gpr_we = 1'b1;
            end
            core_pkg::STORE: mem_op = core_pkg::MEM_STORE;
            default: ;                              // Unknown opcode retires nothing
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.en     <= 1'b0;
            id_ex.gpr_we <= 1'b0;
            id_ex.mem_op <= core_pkg::MEM_NONE;
        end else begin
            id_ex.en     <= valid;
            id_ex.gpr_we <= valid && gpr_we && (rd != '0);  // x0 never written
            id_ex.mem_op <= valid ? mem_op : core_pkg::MEM_NONE;
        end
        id_ex.alu_op      <= alu_op;
        id_ex.alu_in_0    <= rs1_val;
        id_ex.alu_in_1    <= (op == core_pkg::OP)    ? rs2_val :
                             (op == core_pkg::STORE) ? imm_s : imm_i;
        id_ex.mem_wr_data <= rs2_val;
        id_ex.rd_addr     <= rd;
    end

    // Bubble goes to EX while the stalled instruction waits in IF/ID
    a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (!id_ex.en && $stable(if_id)));

endmodule

`default_nettype wire

// ==== rtl/if_stage.sv ====
// Fetch stage holding the PC and the IF/ID pipeline register
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
    parameter int              SPM_ADDR_W = 8,
    parameter core_pkg::word_t RESET_PC   = '0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        run,        // Fetch enable level
    input  wire                        stall,      // Load-use hold
    output logic [SPM_ADDR_W-1:0]      insn_addr,  // Word address to SPM
    input  wire core_pkg::word_t       insn_data,  // Fetched word
    output core_pkg::if_id_t           if_id
);

    core_pkg::word_t pc;                            // Current fetch address

    assign insn_addr = pc[SPM_ADDR_W+1:2];          // Drop byte offset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_id.en <= 1'b0;
        end else if (!stall) begin
            if_id.en <= run;                        // Idle slot while stopped
            if (run) begin
                pc <= pc + 32'd4;
            end
        end
        if (run && !stall) begin                    // Payload follows each advance
            if_id.pc   <= pc;
            if_id.insn <= insn_data;
        end
    end

    // A load-use bubble is one cycle, so fetch never freezes twice in a row
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall);

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
// Memory stage driving the SPM data port and the MEM/WB register
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int SPM_ADDR_W = 8
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire core_pkg::ex_mem_t     ex_mem,
    output logic [SPM_ADDR_W-1:0]      data_addr,     // Word address
    output logic                       data_we,
    output core_pkg::word_t            data_wr,
    input  wire core_pkg::word_t       data_rd,       // Combinational read
    output core_pkg::word_t            mem_fwd_data,  // Result headed for WB
    output core_pkg::gpr_wr_t          wb
);

    assign data_addr    = ex_mem.out[SPM_ADDR_W+1:2];
    assign data_we      = ex_mem.en && (ex_mem.mem_op == core_pkg::MEM_STORE);
    assign data_wr      = ex_mem.mem_wr_data;
    assign mem_fwd_data = (ex_mem.mem_op == core_pkg::MEM_LOAD) ? data_rd : ex_mem.out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.we <= 1'b0;
        end else begin
            wb.we <= ex_mem.en && ex_mem.gpr_we;
        end
        wb.addr <= ex_mem.rd_addr;
        wb.data <= mem_fwd_data;                  // Same value that was forwarded
    end

endmodule

`default_nettype wire

// ==== rtl/spm.sv ====
// Scratch-pad memory with an instruction port and a data port
`timescale 1ns/1ps
`default_nettype none

module spm #(
    parameter int SPM_ADDR_W = 8
) (
    input  wire                        clk,
    input  wire [SPM_ADDR_W-1:0]       insn_addr,     // Fetch or program load
    input  wire                        insn_we,
    input  wire core_pkg::word_t       insn_wr,
    output core_pkg::word_t            insn_data,
    input  wire [SPM_ADDR_W-1:0]       data_addr,     // LW and SW
    input  wire                        data_we,
    input  wire core_pkg::word_t       data_wr,
    output core_pkg::word_t            data_rd
);

    core_pkg::word_t mem [2**SPM_ADDR_W];           // Shared program and data

    always_ff @(posedge clk) begin
        if (insn_we) begin
            mem[insn_addr] <= insn_wr;
        end
        if (data_we) begin
            mem[data_addr] <= data_wr;
        end
    end

    assign insn_data = mem[insn_addr];              // Same-cycle reads
    assign data_rd   = mem[data_addr];

    // Program load only happens with run low, so no store can race it
    a_port_clash: assert property (@(posedge clk)
        !(insn_we && data_we && (insn_addr == data_addr)));

endmodule

`default_nettype wire

// ==== verification/cpu_top_tb.sv ====
// Testbench running a random RV32I subset program on the core against an in-order model
`timescale 1ns/1ps
`default_nettype none

module cpu_top_tb;

    localparam int          SPM_ADDR_W     = 8;
    localparam int          PROG_LEN       = 40;    // Generated instructions
    localparam int          PROG_WORDS     = 64;    // Loaded words with NOP fill
    localparam int          TIMEOUT_CYCLES = 2 * PROG_WORDS + 50;
    localparam int          DRAIN_CYCLES   = 10;    // Watch for stray writebacks
    localparam logic [31:0] SEED           = 32'ha4d;

    typedef enum int {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LW, K_SW} kind_e;

    logic                  clk;
    logic                  rst_n;
    logic                  run;
    logic                  prog_we;
    logic [SPM_ADDR_W-1:0] prog_addr;
    logic [31:0]           prog_data;
    core_pkg::gpr_wr_t     wb;

    kind_e       p_kind [PROG_LEN];                 // Program in model form
    int          p_rd   [PROG_LEN];
    int          p_rs1  [PROG_LEN];
    int          p_rs2  [PROG_LEN];
    int          p_imm  [PROG_LEN];
    logic [31:0] prog_mem [PROG_WORDS];             // Encoded image
    int          prog_len;

    logic [4:0]  exp_addr_q [$];                    // Expected writebacks in order
    logic [31:0] exp_data_q [$];
    int          exp_total;
    logic        head_valid;
    logic [4:0]  head_addr;
    logic [31:0] head_data;
    int          wb_count    = 0;
    int          error_count = 0;
    int          run_cycles  = 0;

    cpu_top #(.SPM_ADDR_W(SPM_ADDR_W), .RESET_PC(32'h0)) cpu_top_i (
        .clk(clk), .rst_n(rst_n), .run(run), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    //////////////////////////////////////////////////
    // Program generation and reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] encode(kind_e k, int rd, int rs1, int rs2, int imm);
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [11:0] i12;
        d   = rd[4:0];
        s1  = rs1[4:0];
        s2  = rs2[4:0];
        i12 = imm[11:0];
        case (k)
            K_ADD:   return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            K_SUB:   return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            K_AND:   return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
            K_OR:    return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
            K_XOR:   return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
            K_ADDI:  return {i12, s1, 3'b000, d, 7'b0010011};
            K_LW:    return {i12, s1, 3'b010, d, 7'b0000011};
            default: return {i12[11:5], s2, s1, 3'b010, i12[4:0], 7'b0100011};
        endcase
    endfunction

    function automatic int rand_imm();
        int r;
        r = $urandom_range(4095, 0);
        return (r >= 2048) ? r - 4096 : r;          // Signed 12-bit
    endfunction

    task automatic add_insn(input kind_e k, input int rd, input int rs1, input int rs2,
                            input int imm);
        p_kind[prog_len]   = k;
        p_rd[prog_len]     = rd;
        p_rs1[prog_len]    = rs1;
        p_rs2[prog_len]    = rs2;
        p_imm[prog_len]    = imm;
        prog_mem[prog_len] = encode(k, rd, rs1, rs2, imm);
        prog_len++;
    endtask

    task automatic gen_program();
        int k;
        int r;
        int rd;
        int rs1;
        int rs2;
        int prev_rd;
        prog_len = 0;
        add_insn(K_ADDI, 1, 0, 0, 512);             // Data base at word 128
        for (k = 0; k < 4; k++) begin
            add_insn(K_SW, 0, 1, 1, 4 * k);         // Seed data words 128 to 131
        end
        for (k = 2; k < 8; k++) begin
            add_insn(K_ADDI, k, k - 1, 0, rand_imm());  // Chained register init
        end
        add_insn(K_ADD, 2, 3, 4, 0);
        add_insn(K_SUB, 5, 2, 6, 0);                // Distance one
        add_insn(K_AND, 6, 2, 5, 0);                // Distances two and one
        add_insn(K_OR,  7, 2, 4, 0);                // Distance three via write-through
        add_insn(K_XOR, 3, 7, 6, 0);
        add_insn(K_SW,  0, 1, 3, 8);
        add_insn(K_ADD, 4, 5, 6, 0);
        add_insn(K_LW,  2, 1, 0, 8);                // Reads back the store
        add_insn(K_ADD, 5, 2, 7, 0);                // Load-use
        prev_rd = 5;
        while (prog_len < PROG_LEN) begin
            r   = $urandom_range(7, 0);
            rd  = $urandom_range(7, 2);             // x1 stays the base
            rs1 = ($urandom_range(1, 0) == 1) ? prev_rd : $urandom_range(7, 0);
            rs2 = $urandom_range(7, 0);
            case (r)
                5: add_insn(K_ADDI, rd, rs1, 0, rand_imm());
                6: add_insn(K_SW, 0, 1, rs2, 4 * $urandom_range(3, 0));
                7: begin
                    add_insn(K_LW, rd, 1, 0, 4 * $urandom_range(3, 0));
                    if (prog_len < PROG_LEN && $urandom_range(1, 0) == 1) begin
                        add_insn(kind_e'($urandom_range(4, 0)), $urandom_range(7, 2), rd, rs2, 0);
                    end
                end
                default: add_insn(kind_e'(r), rd, rs1, rs2, 0);
            endcase
            if (p_kind[prog_len-1] != K_SW) begin
                prev_rd = p_rd[prog_len-1];
            end
        end
        for (k = PROG_LEN; k < PROG_WORDS; k++) begin
            prog_mem[k] = encode(K_ADDI, 0, 0, 0, 0);   // NOP fill
        end
    endtask

    task automatic run_model();
        logic [31:0] x [8];
        logic [31:0] dmem [256];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        int          i;
        for (i = 0; i < 8; i++) begin
            x[i] = '0;
        end
        for (i = 0; i < PROG_LEN; i++) begin
            a    = x[p_rs1[i]];
            b    = x[p_rs2[i]];
            addr = a + 32'(p_imm[i]);
            res  = '0;
            case (p_kind[i])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_ADDI: res = addr;
                K_LW:   res = dmem[addr[9:2]];
                K_SW:   dmem[addr[9:2]] = b;
            endcase
            if (p_kind[i] != K_SW && p_rd[i] != 0) begin
                x[p_rd[i]] = res;
                exp_addr_q.push_back(p_rd[i][4:0]);
                exp_data_q.push_back(res);
            end
        end
        exp_total = exp_addr_q.size();
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[SPM_ADDR_W-1:0];
            prog_data = prog_mem[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Scoreboard and checks
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n && wb.we) begin
            wb_count <= wb_count + 1;
            if (exp_addr_q.size() > 0) begin
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
            end
            head_valid <= (exp_addr_q.size() > 0);  // Next expected entry
            if (exp_addr_q.size() > 0) begin
                head_addr <= exp_addr_q[0];
                head_data <= exp_data_q[0];
            end
        end
    end

    a_idle_before_run: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !wb.we)
        else begin
            error_count++;
            $display("[ERROR] %0t wb.we expected 0 actual %0b", $time, $sampled(wb.we));
        end

    a_wb_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wb.we |-> (wb.addr != 5'd0))
        else begin
            error_count++;
            $display("[ERROR] %0t wb.addr expected nonzero actual 0", $time);
        end

    a_wb_expected: assert property (@(posedge clk) disable iff (!rst_n)
        wb.we |-> head_valid)
        else begin
            error_count++;
            $display("At %0t the core wrote back to x%0d after the model ran out of results",
                     $time, $sampled(wb.addr));
        end

    a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.we && head_valid) |-> (wb.addr == head_addr))
        else begin
            error_count++;
            $display("[ERROR] %0t wb.addr expected %0d actual %0d",
                     $time, $sampled(head_addr), $sampled(wb.addr));
        end

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.we && head_valid) |-> (wb.data == head_data))
        else begin
            error_count++;
            $display("[ERROR] %0t wb.data expected %08h actual %08h",
                     $time, $sampled(head_data), $sampled(wb.data));
        end

    always @(posedge clk) begin
        if (run) begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= TIMEOUT_CYCLES) begin
                $display("Timed out after %0d cycles waiting for writebacks", run_cycles);
                $display("Writebacks: %0d of %0d, errors: %0d",
                         wb_count, exp_total, error_count + 1);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(SEED));
        gen_program();
        run_model();
        head_valid <= (exp_total > 0);
        head_addr  <= exp_addr_q[0];
        head_data  <= exp_data_q[0];
        repeat (10) @(negedge clk);                 // Reset for 10 cycles
        rst_n = 1'b1;
        repeat (3) @(negedge clk);                  // Idle with run low
        load_program();
        run = 1'b1;
        while (wb_count < exp_total) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("Writebacks: %0d of %0d, errors: %0d", wb_count, exp_total, error_count);
        if (error_count == 0 && wb_count == exp_total) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
